// ==== matmul_types_pkg.sv ====
package matmul_types_pkg;

    // Element, address and stride widths shared by every block
    localparam int DATA_WIDTH   = 8;
    localparam int ADDR_WIDTH   = 10;
    localparam int STRIDE_WIDTH = 8;

    // One matrix element
    // All arithmetic on it wraps modulo 2**DATA_WIDTH
    typedef logic [DATA_WIDTH-1:0] data_t;

    // One word address into the A, B or C memory
    typedef logic [ADDR_WIDTH-1:0] addr_t;

    // Distance between consecutive words of one matrix
    typedef logic [STRIDE_WIDTH-1:0] stride_t;

    // One memory word or one output beat
    // Lane 0 sits in the low bits, so word[i] selects lane i directly
    typedef data_t [3:0] lane_word_t;

endpackage

// ==== matmul_timing_pkg.sv ====
package matmul_timing_pkg;

    // Operand flops, product register and accumulator
    localparam int MAC_STAGES  = 3;

    // Read data from the external memories arrives one cycle after the address
    localparam int MEM_LATENCY = 1;

    // Run cycle counter, wide enough for small arrays
    typedef logic [7:0] count_t;

    typedef enum logic [1:0] {
        IDLE,
        RUN,
        FINISHED
    } seq_state_t;

    // Word k is issued at cycle k+1 and shows up on the lanes MEM_LATENCY later.
    // The far corner PE sees the last pair after another 2*(n-1) cycles of skew
    // and forwarding, and the MAC needs MAC_STAGES cycles to fold it in
    function automatic count_t latch_cycle(input int n);
        return count_t'(3 * (n - 1) + 1 + MEM_LATENCY + MAC_STAGES);
    endfunction

    // One capture cycle plus n output beats
    function automatic count_t done_cycle(input int n);
        return count_t'(int'(latch_cycle(n)) + n + 1);
    endfunction

endpackage

// ==== matmul_if.sv ====
`timescale 1ns/1ns

////////////////////////////////////////
// Operand lanes toward the mesh
////////////////////////////////////////

// Carries one A element and one B element per lane and cycle.
// Lanes that carry no data are held at zero, so nothing downstream
// needs the valid flag to keep the sums clean
interface operand_if #(
    parameter int ARRAY_SIZE = 4
);
    import matmul_types_pkg::*;

    data_t a_lane [ARRAY_SIZE];
    data_t b_lane [ARRAY_SIZE];
    logic  operand_valid;

    modport producer (
        output a_lane,
        output b_lane,
        output operand_valid
    );

    modport consumer (
        input a_lane,
        input b_lane,
        input operand_valid
    );

endinterface

////////////////////////////////////////
// Accumulator snapshot of the mesh
////////////////////////////////////////

interface result_if #(
    parameter int ARRAY_SIZE = 4
);
    import matmul_types_pkg::*;

    // acc[i][j] is C[i][j], row first
    data_t acc [ARRAY_SIZE][ARRAY_SIZE];

    modport producer (output acc);
    modport consumer (input acc);

endinterface

// ==== matmul_sequencer.sv ====
`timescale 1ns/1ns

module matmul_sequencer #(
    parameter int ARRAY_SIZE = 4
) (
    input  logic clk,
    input  logic reset,
    input  logic start_mat_mul,
    output logic fetch_active,
    output logic latch_results,
    output logic done_mat_mul
);
    import matmul_timing_pkg::*;

    localparam count_t LATCH_CNT = latch_cycle(ARRAY_SIZE);
    localparam count_t DONE_CNT  = done_cycle(ARRAY_SIZE);

    seq_state_t state;
    count_t     cnt;

    // The counter reads n during cycle n of a run, cycle 0 being the first
    // edge with start_mat_mul high
    always_ff @(posedge clk)
    begin
        if (reset || !start_mat_mul)
        begin
            state <= IDLE;
            cnt   <= '0;
        end
        else
        begin
            case (state)
                IDLE:
                begin
                    state <= RUN;
                    cnt   <= '0;
                end
                RUN:
                begin
                    if (cnt == DONE_CNT)
                        state <= FINISHED;
                    else
                        cnt <= cnt + 1'b1;
                end
                default:
                    // Stay here until start_mat_mul drops
                    state <= FINISHED;
            endcase
        end
    end

    assign fetch_active  = (state == RUN) && (cnt < count_t'(ARRAY_SIZE));
    assign latch_results = (state == RUN) && (cnt == LATCH_CNT);
    assign done_mat_mul  = (state == RUN) && (cnt == DONE_CNT);

endmodule

// ==== operand_fetch.sv ====
`timescale 1ns/1ns

module operand_fetch #(
    parameter int ARRAY_SIZE = 4
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          start_mat_mul,
    input  logic                          fetch_active,
    input  matmul_types_pkg::addr_t       address_mat_a,
    input  matmul_types_pkg::addr_t       address_mat_b,
    input  matmul_types_pkg::stride_t     address_stride_a,
    input  matmul_types_pkg::stride_t     address_stride_b,
    output matmul_types_pkg::addr_t       a_addr,
    output matmul_types_pkg::addr_t       b_addr,
    input  matmul_types_pkg::lane_word_t  a_data,
    input  matmul_types_pkg::lane_word_t  b_data,
    operand_if.producer                   ops
);
    import matmul_types_pkg::*;
    import matmul_timing_pkg::*;

    // Bit 0 marks a cycle with a fresh address on the bus, the top bit marks
    // the cycle in which the matching word comes back
    logic [MEM_LATENCY:0] valid_pipe;
    logic                 data_valid;

    ////////////////////////////////////////
    // Address stepping
    ////////////////////////////////////////

    // Parked one stride below the base, so the first step lands on word 0
    always_ff @(posedge clk)
    begin
        if (reset || !start_mat_mul)
        begin
            a_addr <= address_mat_a - addr_t'(address_stride_a);
            b_addr <= address_mat_b - addr_t'(address_stride_b);
        end
        else if (fetch_active)
        begin
            a_addr <= a_addr + addr_t'(address_stride_a);
            b_addr <= b_addr + addr_t'(address_stride_b);
        end
    end

    ////////////////////////////////////////
    // Read data qualification
    ////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (reset || !start_mat_mul)
            valid_pipe <= '0;
        else
            valid_pipe <= {valid_pipe[MEM_LATENCY-1:0], fetch_active};
    end

    assign data_valid        = valid_pipe[MEM_LATENCY];
    assign ops.operand_valid = data_valid;

    // A words are columns of A and B words are rows of B, so both unpack
    // straight onto the lanes
    for (genvar i = 0; i < ARRAY_SIZE; i++)
    begin : g_lane
        assign ops.a_lane[i] = data_valid ? a_data[i] : '0;
        assign ops.b_lane[i] = data_valid ? b_data[i] : '0;
    end

endmodule

// ==== operand_skew.sv ====
`timescale 1ns/1ns

module operand_skew #(
    parameter int ARRAY_SIZE = 4
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        start_mat_mul,
    operand_if.consumer raw,
    operand_if.producer skewed
);
    import matmul_types_pkg::*;

    // Recent history of the raw valid flag.
    // It keeps the skewed window open until the last lane has drained,
    // one cycle longer than strictly needed
    logic [ARRAY_SIZE-1:0] valid_hist;

    always_ff @(posedge clk)
    begin
        if (reset || !start_mat_mul)
            valid_hist <= '0;
        else
            valid_hist <= {valid_hist[ARRAY_SIZE-2:0], raw.operand_valid};
    end

    assign skewed.operand_valid = raw.operand_valid || (valid_hist != '0);

    // Lane i waits i cycles so that A[i][k] and B[k][j] meet in PE(i,j)
    for (genvar i = 0; i < ARRAY_SIZE; i++)
    begin : g_lane
        if (i == 0)
        begin : g_direct
            assign skewed.a_lane[0] = raw.a_lane[0];
            assign skewed.b_lane[0] = raw.b_lane[0];
        end
        else
        begin : g_delay
            data_t a_dly [i];
            data_t b_dly [i];

            always_ff @(posedge clk)
            begin
                if (reset || !start_mat_mul)
                begin
                    for (int s = 0; s < i; s++)
                    begin
                        a_dly[s] <= '0;
                        b_dly[s] <= '0;
                    end
                end
                else
                begin
                    a_dly[0] <= raw.a_lane[i];
                    b_dly[0] <= raw.b_lane[i];
                    for (int s = 1; s < i; s++)
                    begin
                        a_dly[s] <= a_dly[s-1];
                        b_dly[s] <= b_dly[s-1];
                    end
                end
            end

            assign skewed.a_lane[i] = a_dly[i-1];
            assign skewed.b_lane[i] = b_dly[i-1];
        end
    end

endmodule

// ==== processing_element.sv ====
`timescale 1ns/1ns

module processing_element (
    input  logic                     clk,
    input  logic                     clear,
    input  matmul_types_pkg::data_t  in_a,
    input  matmul_types_pkg::data_t  in_b,
    output matmul_types_pkg::data_t  out_a,
    output matmul_types_pkg::data_t  out_b,
    output matmul_types_pkg::data_t  acc
);
    import matmul_types_pkg::*;
    import matmul_timing_pkg::*;

    // Everything ahead of the product register and the accumulator
    localparam int OPND_STAGES = MAC_STAGES - 2;

    data_t a_q [OPND_STAGES];
    data_t b_q [OPND_STAGES];
    data_t product;

    always_ff @(posedge clk)
    begin
        if (clear)
        begin
            for (int s = 0; s < OPND_STAGES; s++)
            begin
                a_q[s] <= '0;
                b_q[s] <= '0;
            end
            product <= '0;
            acc     <= '0;
        end
        else
        begin
            a_q[0] <= in_a;
            b_q[0] <= in_b;
            for (int s = 1; s < OPND_STAGES; s++)
            begin
                a_q[s] <= a_q[s-1];
                b_q[s] <= b_q[s-1];
            end
            // Both wrap at the element width
            product <= a_q[OPND_STAGES-1] * b_q[OPND_STAGES-1];
            acc     <= acc + product;
        end
    end

    // The first operand stage doubles as the link to the right and lower neighbours
    assign out_a = a_q[0];
    assign out_b = b_q[0];

endmodule

// ==== pe_array.sv ====
`timescale 1ns/1ns

module pe_array #(
    parameter int ARRAY_SIZE = 4
) (
    input  logic        clk,
    input  logic        reset,
    input  logic        start_mat_mul,
    operand_if.consumer ops,
    result_if.producer  res
);
    import matmul_types_pkg::*;

    // Operands entering the mesh at the left column and top row
    data_t edge_a [ARRAY_SIZE];
    data_t edge_b [ARRAY_SIZE];

    // Forwarded operands leaving PE(i,j) to the right and downward
    data_t a_fwd [ARRAY_SIZE][ARRAY_SIZE];
    data_t b_fwd [ARRAY_SIZE][ARRAY_SIZE];

    // Accumulators start from zero for every run
    logic pe_clear;

    assign pe_clear = reset || !start_mat_mul;

    for (genvar k = 0; k < ARRAY_SIZE; k++)
    begin : g_edge
        assign edge_a[k] = ops.operand_valid ? ops.a_lane[k] : '0;
        assign edge_b[k] = ops.operand_valid ? ops.b_lane[k] : '0;
    end

    ////////////////////////////////////////
    // Mesh of processing elements
    ////////////////////////////////////////

    for (genvar i = 0; i < ARRAY_SIZE; i++)
    begin : g_row
        for (genvar j = 0; j < ARRAY_SIZE; j++)
        begin : g_col
            data_t a_in;
            data_t b_in;

            if (j == 0)
            begin : g_left
                assign a_in = edge_a[i];
            end
            else
            begin : g_from_left
                assign a_in = a_fwd[i][j-1];
            end

            if (i == 0)
            begin : g_top
                assign b_in = edge_b[j];
            end
            else
            begin : g_from_above
                assign b_in = b_fwd[i-1][j];
            end

            processing_element pe_i (
                .clk   (clk),
                .clear (pe_clear),
                .in_a  (a_in),
                .in_b  (b_in),
                .out_a (a_fwd[i][j]),
                .out_b (b_fwd[i][j]),
                .acc   (res.acc[i][j])
            );
        end
    end

endmodule

// ==== result_drain.sv ====
`timescale 1ns/1ns

module result_drain #(
    parameter int ARRAY_SIZE = 4
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          start_mat_mul,
    input  logic                          latch_results,
    input  matmul_types_pkg::addr_t       address_mat_c,
    input  matmul_types_pkg::stride_t     address_stride_c,
    result_if.consumer                    res,
    output matmul_types_pkg::lane_word_t  c_data_out,
    output matmul_types_pkg::addr_t       c_addr,
    output logic                          c_data_available
);
    import matmul_types_pkg::*;
    import matmul_timing_pkg::*;

    // Column j of C as an output word, C[i][j] in lane i
    lane_word_t col_w [ARRAY_SIZE];

    // Columns still to be sent, head first
    lane_word_t col_q [ARRAY_SIZE];

    count_t beat_cnt;

    always_comb
    begin
        for (int j = 0; j < ARRAY_SIZE; j++)
        begin
            col_w[j] = '0;
            for (int i = 0; i < ARRAY_SIZE; i++)
            begin
                col_w[j][i] = res.acc[i][j];
            end
        end
    end

    ////////////////////////////////////////
    // Column shift register and C address
    ////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (latch_results)
        begin
            col_q  <= col_w;
            c_addr <= address_mat_c;
        end
        else if (c_data_available)
        begin
            for (int k = 0; k < ARRAY_SIZE - 1; k++)
            begin
                col_q[k] <= col_q[k+1];
            end
            col_q[ARRAY_SIZE-1] <= '0;
            c_addr <= c_addr + addr_t'(address_stride_c);
        end
    end

    assign c_data_out = col_q[0];

    // Beat counter, one per column
    always_ff @(posedge clk)
    begin
        if (reset || !start_mat_mul)
        begin
            c_data_available <= 1'b0;
            beat_cnt         <= '0;
        end
        else if (latch_results)
        begin
            c_data_available <= 1'b1;
            beat_cnt         <= count_t'(1);
        end
        else if (c_data_available)
        begin
            if (beat_cnt == count_t'(ARRAY_SIZE))
                c_data_available <= 1'b0;
            else
                beat_cnt <= beat_cnt + 1'b1;
        end
    end

endmodule

// ==== systolic_matmul.sv ====
`timescale 1ns/1ns

module systolic_matmul #(
    parameter int ARRAY_SIZE = 4
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          start_mat_mul,
    output logic                          done_mat_mul,
    input  matmul_types_pkg::addr_t       address_mat_a,
    input  matmul_types_pkg::addr_t       address_mat_b,
    input  matmul_types_pkg::addr_t       address_mat_c,
    input  matmul_types_pkg::stride_t     address_stride_a,
    input  matmul_types_pkg::stride_t     address_stride_b,
    input  matmul_types_pkg::stride_t     address_stride_c,
    output matmul_types_pkg::addr_t       a_addr,
    output matmul_types_pkg::addr_t       b_addr,
    input  matmul_types_pkg::lane_word_t  a_data,
    input  matmul_types_pkg::lane_word_t  b_data,
    output matmul_types_pkg::lane_word_t  c_data_out,
    output matmul_types_pkg::addr_t       c_addr,
    output logic                          c_data_available
);
    import matmul_types_pkg::*;

    logic fetch_active;
    logic latch_results;

    operand_if #(.ARRAY_SIZE(ARRAY_SIZE)) raw_ops ();
    operand_if #(.ARRAY_SIZE(ARRAY_SIZE)) mesh_ops ();
    result_if  #(.ARRAY_SIZE(ARRAY_SIZE)) results ();

    matmul_sequencer #(.ARRAY_SIZE(ARRAY_SIZE)) sequencer_i (
        .clk           (clk),
        .reset         (reset),
        .start_mat_mul (start_mat_mul),
        .fetch_active  (fetch_active),
        .latch_results (latch_results),
        .done_mat_mul  (done_mat_mul)
    );

    // Memory side, strided reads of A columns and B rows
    operand_fetch #(.ARRAY_SIZE(ARRAY_SIZE)) fetch_i (
        .clk              (clk),
        .reset            (reset),
        .start_mat_mul    (start_mat_mul),
        .fetch_active     (fetch_active),
        .address_mat_a    (address_mat_a),
        .address_mat_b    (address_mat_b),
        .address_stride_a (address_stride_a),
        .address_stride_b (address_stride_b),
        .a_addr           (a_addr),
        .b_addr           (b_addr),
        .a_data           (a_data),
        .b_data           (b_data),
        .ops              (raw_ops.producer)
    );

    operand_skew #(.ARRAY_SIZE(ARRAY_SIZE)) skew_i (
        .clk           (clk),
        .reset         (reset),
        .start_mat_mul (start_mat_mul),
        .raw           (raw_ops.consumer),
        .skewed        (mesh_ops.producer)
    );

    pe_array #(.ARRAY_SIZE(ARRAY_SIZE)) array_i (
        .clk           (clk),
        .reset         (reset),
        .start_mat_mul (start_mat_mul),
        .ops           (mesh_ops.consumer),
        .res           (results.producer)
    );

    result_drain #(.ARRAY_SIZE(ARRAY_SIZE)) drain_i (
        .clk              (clk),
        .reset            (reset),
        .start_mat_mul    (start_mat_mul),
        .latch_results    (latch_results),
        .address_mat_c    (address_mat_c),
        .address_stride_c (address_stride_c),
        .res              (results.consumer),
        .c_data_out       (c_data_out),
        .c_addr           (c_addr),
        .c_data_available (c_data_available)
    );

endmodule

// ==== systolic_matmul_checker.sv ====
`timescale 1ns/1ns

module systolic_matmul_checker #(
    parameter int ARRAY_SIZE = 4
) (
    input logic clk,
    input logic reset,
    input logic start_mat_mul,
    input logic done_mat_mul,
    input logic c_data_available
);

    // Count of failed assertions, read by the testbench at the end of the run
    int assert_failures = 0;

    done_single: assert property (@(posedge clk) disable iff (reset)
        done_mat_mul |=> !done_mat_mul)
    else
    begin
        assert_failures++;
        $error("done_mat_mul stayed high for more than one cycle");
    end

    avail_in_run: assert property (@(posedge clk) disable iff (reset)
        c_data_available |-> start_mat_mul)
    else
    begin
        assert_failures++;
        $error("c_data_available high while start_mat_mul is low");
    end

    // The strobe covers exactly one beat per column
    avail_length: assert property (@(posedge clk) disable iff (reset)
        $rose(c_data_available) |-> c_data_available [*ARRAY_SIZE] ##1 !c_data_available)
    else
    begin
        assert_failures++;
        $error("c_data_available did not last exactly %0d cycles", ARRAY_SIZE);
    end

endmodule

bind systolic_matmul systolic_matmul_checker #(.ARRAY_SIZE(ARRAY_SIZE)) protocol_chk_i (
    .clk              (clk),
    .reset            (reset),
    .start_mat_mul    (start_mat_mul),
    .done_mat_mul     (done_mat_mul),
    .c_data_available (c_data_available)
);

// ==== systolic_matmul_monitor.sv ====
`timescale 1ns/1ns

module systolic_matmul_monitor #(
    parameter int ARRAY_SIZE = 4
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          start_mat_mul,
    input  logic                          done_mat_mul,
    input  logic                          c_data_available,
    input  matmul_types_pkg::lane_word_t  c_data_out,
    input  matmul_types_pkg::addr_t       c_addr,
    input  matmul_types_pkg::lane_word_t  exp_cols [ARRAY_SIZE],
    input  matmul_types_pkg::addr_t       exp_c_base,
    input  matmul_types_pkg::stride_t     exp_c_stride,
    output int                            error_count,
    output int                            done_count
);
    import matmul_types_pkg::*;

    int    beat_idx;
    logic  prev_avail;
    logic  done_seen;
    addr_t exp_addr;

    initial
    begin
        error_count = 0;
        done_count  = 0;
        beat_idx    = 0;
        prev_avail  = 1'b0;
        done_seen   = 1'b0;
    end

    // Outputs are registered in the DUT, so the values seen at the edge are settled
    always @(posedge clk)
    begin
        if (reset || !start_mat_mul)
        begin
            if (done_mat_mul || c_data_available)
            begin
                $display("%0t: done or data strobe went high while %s", $time,
                         reset ? "in reset" : "idle");
                error_count++;
            end
            beat_idx  = 0;
            done_seen = 1'b0;
        end
        else
        begin
            if (c_data_available)
            begin
                if (beat_idx >= ARRAY_SIZE)
                begin
                    $display("%0t: more than %0d result beats in one run", $time, ARRAY_SIZE);
                    error_count++;
                end
                else
                begin
                    exp_addr = exp_c_base + addr_t'(beat_idx) * addr_t'(exp_c_stride);
                    if (c_data_out !== exp_cols[beat_idx])
                    begin
                        $display("mismatch at %0t: beat %0d data expected %h got %h",
                                 $time, beat_idx, exp_cols[beat_idx], c_data_out);
                        error_count++;
                    end
                    if (c_addr !== exp_addr)
                    begin
                        $display("mismatch at %0t: beat %0d address expected %h got %h",
                                 $time, beat_idx, exp_addr, c_addr);
                        error_count++;
                    end
                end
                beat_idx++;
            end
            if (done_mat_mul)
            begin
                if (done_seen)
                begin
                    $display("%0t: done_mat_mul asserted twice in one run", $time);
                    error_count++;
                end
                else if (beat_idx != ARRAY_SIZE || !prev_avail)
                begin
                    $display("%0t: done_mat_mul came after %0d beats, not right after the last",
                             $time, beat_idx);
                    error_count++;
                end
                done_seen = 1'b1;
                done_count++;
            end
        end
        prev_avail = c_data_available;
    end

endmodule

// ==== systolic_matmul_tb.sv ====
`timescale 1ns/1ns

module systolic_matmul_tb;
    import matmul_types_pkg::*;

    localparam int ARRAY_SIZE   = 4;
    localparam int CLK_PERIOD   = 40;
    localparam int RESET_CYCLES = 16;
    localparam int NUM_RUNS     = 8;
    localparam int MEM_WORDS    = 1 << ADDR_WIDTH;
    localparam int RUN_CYCLES   = int'(matmul_timing_pkg::done_cycle(ARRAY_SIZE)) + 8;
    localparam int TIMEOUT_NS   = (NUM_RUNS * RUN_CYCLES + RESET_CYCLES) * CLK_PERIOD;

    logic       clk;
    logic       reset;
    logic       start_mat_mul;
    logic       done_mat_mul;
    addr_t      address_mat_a;
    addr_t      address_mat_b;
    addr_t      address_mat_c;
    stride_t    address_stride_a;
    stride_t    address_stride_b;
    stride_t    address_stride_c;
    addr_t      a_addr;
    addr_t      b_addr;
    lane_word_t a_data;
    lane_word_t b_data;
    lane_word_t c_data_out;
    addr_t      c_addr;
    logic       c_data_available;

    lane_word_t mem_a [MEM_WORDS];
    lane_word_t mem_b [MEM_WORDS];
    addr_t      a_rd;
    addr_t      b_rd;
    data_t      mat_a [ARRAY_SIZE][ARRAY_SIZE];
    data_t      mat_b [ARRAY_SIZE][ARRAY_SIZE];
    lane_word_t exp_cols [ARRAY_SIZE];
    integer     seed;
    int         error_count;
    int         done_count;
    int         test_count;
    int         test_fails;
    int         total_errors;

    systolic_matmul #(.ARRAY_SIZE(ARRAY_SIZE)) systolic_matmul_i (.*);

    systolic_matmul_monitor #(.ARRAY_SIZE(ARRAY_SIZE)) monitor_i (
        .clk              (clk),
        .reset            (reset),
        .start_mat_mul    (start_mat_mul),
        .done_mat_mul     (done_mat_mul),
        .c_data_available (c_data_available),
        .c_data_out       (c_data_out),
        .c_addr           (c_addr),
        .exp_cols         (exp_cols),
        .exp_c_base       (address_mat_c),
        .exp_c_stride     (address_stride_c),
        .error_count      (error_count),
        .done_count       (done_count)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    ////////////////////////////////////////
    // Memory model, one cycle read latency
    ////////////////////////////////////////

    always @(posedge clk)
    begin
        a_rd = a_addr;
        b_rd = b_addr;
        #2;
        a_data = mem_a[a_rd];
        b_data = mem_b[b_rd];
    end

    task automatic next_edge();
        @(posedge clk);
        #2;
    endtask

    function automatic int error_total();
        return error_count + systolic_matmul_i.protocol_chk_i.assert_failures;
    endfunction

    function automatic stride_t random_stride();
        stride_t s;
        s = stride_t'($random(seed));
        if (s == '0)
            s = stride_t'(1);
        return s;
    endfunction

    // Background so that a read from a wrong address returns wrong data
    task automatic fill_memories();
        for (int w = 0; w < MEM_WORDS; w++)
        begin
            mem_a[w] = lane_word_t'(w * 32'h9e3779b1);
            mem_b[w] = lane_word_t'(~(w * 32'h85ebca6b));
        end
    endtask

    // Kind 1 makes A the identity, kind 2 makes A all zero, B is always random
    task automatic make_matrices(input int kind);
        for (int i = 0; i < ARRAY_SIZE; i++)
        begin
            for (int k = 0; k < ARRAY_SIZE; k++)
            begin
                case (kind)
                    1:       mat_a[i][k] = (i == k) ? data_t'(1) : data_t'(0);
                    2:       mat_a[i][k] = '0;
                    default: mat_a[i][k] = data_t'($random(seed));
                endcase
                mat_b[i][k] = data_t'($random(seed));
            end
        end
    endtask

    // Word k of A is column k, word k of B is row k
    task automatic load_operands();
        lane_word_t wa;
        lane_word_t wb;
        for (int k = 0; k < ARRAY_SIZE; k++)
        begin
            for (int l = 0; l < ARRAY_SIZE; l++)
            begin
                wa[l] = mat_a[l][k];
                wb[l] = mat_b[k][l];
            end
            mem_a[address_mat_a + addr_t'(k) * addr_t'(address_stride_a)] = wa;
            mem_b[address_mat_b + addr_t'(k) * addr_t'(address_stride_b)] = wb;
        end
    endtask

    // C[i][j] is the sum over k of A[i][k]*B[k][j], modulo 256
    task automatic compute_expected();
        int s;
        for (int j = 0; j < ARRAY_SIZE; j++)
        begin
            for (int i = 0; i < ARRAY_SIZE; i++)
            begin
                s = 0;
                for (int k = 0; k < ARRAY_SIZE; k++)
                    s += int'(mat_a[i][k]) * int'(mat_b[k][j]);
                exp_cols[j][i] = data_t'(s % 256);
            end
        end
    endtask

    task automatic run_matmul(input string name);
        int errors_before;
        int dones_before;
        errors_before    = error_total();
        dones_before     = done_count;
        address_mat_a    = addr_t'($random(seed));
        address_mat_b    = addr_t'($random(seed));
        address_mat_c    = addr_t'($random(seed));
        address_stride_a = random_stride();
        address_stride_b = random_stride();
        address_stride_c = random_stride();
        load_operands();
        compute_expected();
        next_edge();
        start_mat_mul = 1'b1;
        while (done_count == dones_before)
            next_edge();
        // Hold start a little longer to catch a second done pulse
        repeat (2) next_edge();
        start_mat_mul = 1'b0;
        // The next run adds the second idle cycle before raising start
        next_edge();
        test_count++;
        if (error_total() != errors_before)
            test_fails++;
        $display("test %0d %s: %s", test_count, name,
                 (error_total() == errors_before) ? "ok" : "failed");
    endtask

    ////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////

    initial
    begin
        seed             = 32'h229d8bca;
        reset            = 1'b1;
        start_mat_mul    = 1'b0;
        address_mat_a    = '0;
        address_mat_b    = '0;
        address_mat_c    = '0;
        address_stride_a = stride_t'(1);
        address_stride_b = stride_t'(1);
        address_stride_c = stride_t'(1);
        a_data           = '0;
        b_data           = '0;
        test_count       = 0;
        test_fails       = 0;
        fill_memories();
        repeat (RESET_CYCLES) next_edge();
        reset = 1'b0;
        repeat (3) next_edge();

        make_matrices(1);
        run_matmul("identity A times random B");
        make_matrices(2);
        run_matmul("zero A times random B");
        for (int t = 2; t < NUM_RUNS; t++)
        begin
            make_matrices(0);
            run_matmul("random A and B with strides");
        end

        total_errors = error_total();
        if (done_count != NUM_RUNS)
        begin
            $display("expected %0d done pulses but saw %0d", NUM_RUNS, done_count);
            total_errors++;
        end
        $display("%0d tests run, %0d failed, %0d errors", test_count, test_fails, total_errors);
        if (total_errors == 0 && test_fails == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

    // Watchdog
    initial
    begin
        #(TIMEOUT_NS);
        $display("timeout: the runs did not finish within %0d ns", TIMEOUT_NS);
        $display("** FAIL **");
        $finish;
    end

endmodule

// ==== compile.f ====
matmul_types_pkg.sv
matmul_timing_pkg.sv
matmul_if.sv
matmul_sequencer.sv
operand_fetch.sv
operand_skew.sv
processing_element.sv
pe_array.sv
result_drain.sv
systolic_matmul.sv
systolic_matmul_checker.sv
systolic_matmul_monitor.sv
systolic_matmul_tb.sv
